// ==== hdl/printerPkg.sv ====
//----------------------------------------
// line format constants and ASCII codes
// shared by the hex converter, the channel
// label generator and the line assembler
//----------------------------------------
package printerPkg;

    //----------------------------------------
    // line layout
    //----------------------------------------
    localparam int hexDigits = 4;   // hex digits per sample
    localparam int labelLen  = 4;   // C, tens, ones, equals
    localparam int lineLen   = 9;   // label + hex digits + newline
    localparam int chanBits  = 4;   // channel number width

    //----------------------------------------
    // ASCII codes
    //----------------------------------------
    // digit 0, base for 0..9
    localparam logic [7:0] asciiZero      = 8'h30;
    // 'a' minus ten, base for nibbles 10..15
    localparam logic [7:0] asciiHexOffset = 8'h57;
    localparam logic [7:0] asciiNewline   = 8'h0a;  // line feed
    localparam logic [7:0] asciiLabelC    = 8'h43;  // upper case C
    localparam logic [7:0] asciiEquals    = 8'h3d;  // '='

endpackage

// ==== hdl/uartPkg.sv ====
//----------------------------------------
// 8N1 serial frame constants, used by the
// transmitter and as the default bit period
// of the printer top level
//----------------------------------------
package uartPkg;

    localparam int dataBits  = 8;   // data bits per frame, LSB first
    localparam int frameBits = 10;  // start + data + stop

    // 100 MHz clock at 115200 baud
    localparam int defaultClkPerBit = 868;

endpackage

// ==== hdl/hexAsciiConvert.sv ====
//----------------------------------------
// sample to lowercase hex ASCII plus newline
// 3-stage pipeline, one sample per strobe
// result valid 3 cycles after captureStrobe
//----------------------------------------
`timescale 1ns/100ps

module hexAsciiConvert #(
    parameter int pBitLen = 16                  // sample width, 4 bits per digit
)(
    input  logic                   iSysClk,
    input  logic                   rstN,
    input  logic                   captureStrobe,  // new sample this cycle
    input  logic [pBitLen-1:0]     capturedData,
    output logic [2*pBitLen+7:0]   asciiLine,      // msd first ... lsd, newline
    output logic                   asciiValid
);

    localparam int lpDigits = printerPkg::hexDigits;

    //----------------------------------------
    // stage 1, register the sample
    //----------------------------------------
    logic [pBitLen-1:0] sampleReg;
    logic               valid1;

    always_ff @(posedge iSysClk)
    begin
        if (captureStrobe)
            sampleReg <= capturedData;
    end

    //----------------------------------------
    // stage 2, per nibble codes
    //----------------------------------------
    logic [lpDigits-1:0] belowTen;          // nibble 0..9
    logic [7:0]          digitCode  [lpDigits];
    logic [7:0]          letterCode [lpDigits];
    logic                valid2;

    always_ff @(posedge iSysClk)
    begin
        for (int i = 0; i < lpDigits; i++)
        begin
            belowTen[i]   <= sampleReg[i*4 +: 4] < 4'd10;
            digitCode[i]  <= printerPkg::asciiZero + {4'd0, sampleReg[i*4 +: 4]};
            letterCode[i] <= printerPkg::asciiHexOffset + {4'd0, sampleReg[i*4 +: 4]};
        end
    end

    //----------------------------------------
    // stage 3, pick digit or letter
    //----------------------------------------
    logic valid3;

    always_ff @(posedge iSysClk)
    begin
        asciiLine[7:0] <= printerPkg::asciiNewline;     // newline in the lowest byte
        for (int i = 0; i < lpDigits; i++)
        begin
            // nibble i lands one byte above the newline, msb nibble on top
            asciiLine[(i+1)*8 +: 8] <= belowTen[i] ? digitCode[i] : letterCode[i];
        end
    end

    // valid chain, the only state with reset
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
        end
        else
        begin
            valid1 <= captureStrobe;
            valid2 <= valid1;
            valid3 <= valid2;
        end
    end

    assign asciiValid = valid3;

endmodule

// ==== hdl/channelLabelGen.sv ====
//----------------------------------------
// channel number to "C", tens, ones, "="
// 3-stage pipeline, latency matched to the
// hex converter so both results line up
//----------------------------------------
`timescale 1ns/100ps

module channelLabelGen (
    input  logic                              iSysClk,
    input  logic                              rstN,
    input  logic                              captureStrobe,
    input  logic [printerPkg::chanBits-1:0]   capturedChan,
    output logic [printerPkg::labelLen*8-1:0] labelBytes,   // first byte on top
    output logic                              labelValid
);

    //----------------------------------------
    // stage 1, register the channel
    //----------------------------------------
    logic [printerPkg::chanBits-1:0] chanReg;
    logic                            valid1;

    always_ff @(posedge iSysClk)
    begin
        if (captureStrobe)
            chanReg <= capturedChan;
    end

    //----------------------------------------
    // stage 2, split into tens and ones
    //----------------------------------------
    logic       tensDigit;          // 0 or 1 for a 4-bit channel
    logic [3:0] onesDigit;
    logic       valid2;

    always_ff @(posedge iSysClk)
    begin
        if (chanReg >= 4'd10)
        begin
            tensDigit <= 1'b1;
            onesDigit <= chanReg - 4'd10;
        end
        else
        begin
            tensDigit <= 1'b0;
            onesDigit <= chanReg;
        end
    end

    //----------------------------------------
    // stage 3, ASCII label
    //----------------------------------------
    logic valid3;

    always_ff @(posedge iSysClk)
    begin
        labelBytes <= {printerPkg::asciiLabelC,
                       printerPkg::asciiZero + {7'd0, tensDigit},
                       printerPkg::asciiZero + {4'd0, onesDigit},
                       printerPkg::asciiEquals};
    end

    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
        end
        else
        begin
            valid1 <= captureStrobe;
            valid2 <= valid1;
            valid3 <= valid2;
        end
    end

    assign labelValid = valid3;

endmodule

// ==== hdl/lineAssembler.sv ====
//----------------------------------------
// input req/ack handshake, nine byte line
// buffer and byte handoff to the UART tx
// one line in flight, txBusy blocks new ack
//----------------------------------------
`timescale 1ns/100ps

module lineAssembler #(
    parameter int pBitLen = 16
)(
    input  logic                              iSysClk,
    input  logic                              rstN,
    // producer side
    input  logic                              sampleReq,
    input  logic [pBitLen-1:0]                sampleData,
    input  logic [printerPkg::chanBits-1:0]   channelId,
    output logic                              sampleAck,
    // to both pipelines
    output logic                              captureStrobe,
    output logic [pBitLen-1:0]                capturedData,
    output logic [printerPkg::chanBits-1:0]   capturedChan,
    // pipeline results
    input  logic [2*pBitLen+7:0]              asciiLine,
    input  logic                              asciiValid,
    input  logic [printerPkg::labelLen*8-1:0] labelBytes,
    input  logic                              labelValid,
    // transmitter side
    output logic                              byteReq,
    output logic [7:0]                        byteData,
    input  logic                              byteAck,
    input  logic                              frameActive,
    output logic                              txBusy
);

    localparam int lpBufBits = printerPkg::lineLen * 8;
    localparam int lpIdxW    = $clog2(printerPkg::lineLen + 1);
    localparam logic [lpIdxW-1:0] lpLastIdx = lpIdxW'(printerPkg::lineLen);

    // FSM encoding
    localparam logic [1:0] stIdle  = 2'd0;  // waiting for a request
    localparam logic [1:0] stWait  = 2'd1;  // pipelines running
    localparam logic [1:0] stSend  = 2'd2;  // byte handshakes
    localparam logic [1:0] stDrain = 2'd3;  // last frame on the wire

    logic [1:0]           state;
    logic [lpBufBits-1:0] lineBuf;      // next byte always in the top 8 bits
    logic [lpIdxW-1:0]    byteIdx;      // bytes acked so far

    //----------------------------------------
    // payload capture and line buffer
    //----------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (state == stIdle && sampleReq && !sampleAck && !txBusy)
        begin
            capturedData <= sampleData;
            capturedChan <= channelId;
        end

        if (state == stWait && asciiValid && labelValid)
            lineBuf <= {labelBytes, asciiLine};     // label first, then hex and newline
        else if (state == stSend && byteReq && byteAck)
            lineBuf <= lineBuf << 8;                // move the next byte up
    end

    assign byteData = lineBuf[lpBufBits-1 -: 8];

    //----------------------------------------
    // control FSM
    //----------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            state         <= stIdle;
            sampleAck     <= 1'b0;
            captureStrobe <= 1'b0;
            byteReq       <= 1'b0;
            byteIdx       <= '0;
            txBusy        <= 1'b0;
        end
        else
        begin
            captureStrobe <= 1'b0;              // one cycle pulse

            // release phase of the input handshake, any state
            if (sampleAck && !sampleReq)
                sampleAck <= 1'b0;

            case (state)
                stIdle:
                begin
                    if (sampleReq && !sampleAck && !txBusy)
                    begin
                        sampleAck     <= 1'b1;
                        captureStrobe <= 1'b1;
                        txBusy        <= 1'b1;
                        state         <= stWait;
                    end
                end
                stWait:
                begin
                    if (asciiValid && labelValid)
                    begin
                        byteIdx <= '0;
                        byteReq <= 1'b1;        // offer byte 0 right away
                        state   <= stSend;
                    end
                end
                stSend:
                begin
                    if (byteReq && byteAck)
                    begin
                        byteReq <= 1'b0;        // tx has latched it
                        byteIdx <= byteIdx + 1'b1;
                    end
                    else if (!byteReq && !byteAck)
                    begin
                        if (byteIdx == lpLastIdx)
                            state <= stDrain;   // all nine handed over
                        else
                            byteReq <= 1'b1;
                    end
                end
                default:
                begin
                    // stop bit of the last byte done
                    if (!frameActive)
                    begin
                        txBusy <= 1'b0;
                        state  <= stIdle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/uartTx.sv ====
//----------------------------------------
// 8N1 serializer with byte req/ack
// ack rises when a byte is latched and only
// once the previous frame has finished
//----------------------------------------
`timescale 1ns/100ps

module uartTx #(
    parameter int pClkPerBit = uartPkg::defaultClkPerBit   // clocks per bit
)(
    input  logic       iSysClk,
    input  logic       rstN,
    input  logic       byteReq,
    input  logic [7:0] byteData,
    output logic       byteAck,
    output logic       txd,
    output logic       frameActive      // high from start bit to end of stop bit
);

    localparam int lpCntW = $clog2(pClkPerBit + 1);
    localparam int lpIdxW = $clog2(uartPkg::frameBits);
    localparam logic [lpCntW-1:0] lpLastCnt = lpCntW'(pClkPerBit - 1);
    localparam logic [lpIdxW-1:0] lpLastBit = lpIdxW'(uartPkg::frameBits - 1);
    localparam logic [lpIdxW-1:0] lpDataEnd = lpIdxW'(uartPkg::dataBits);

    logic [lpCntW-1:0]            clkCnt;     // cycles within the bit
    logic [lpIdxW-1:0]            bitIdx;     // 0 start, 1..8 data, 9 stop
    logic [uartPkg::dataBits-1:0] shiftReg;   // data bits still to send

    always_ff @(posedge iSysClk)
    begin
        if (!rstN)
        begin
            txd         <= 1'b1;    // line idles high
            frameActive <= 1'b0;
            byteAck     <= 1'b0;
            clkCnt      <= '0;
            bitIdx      <= '0;
        end
        else
        begin
            // drop ack once the requester has let go
            if (byteAck && !byteReq)
                byteAck <= 1'b0;

            if (!frameActive)
            begin
                if (byteReq && !byteAck)
                begin
                    shiftReg    <= byteData;
                    byteAck     <= 1'b1;
                    txd         <= 1'b0;        // start bit
                    frameActive <= 1'b1;
                    clkCnt      <= '0;
                    bitIdx      <= '0;
                end
            end
            else if (clkCnt == lpLastCnt)
            begin
                clkCnt <= '0;
                if (bitIdx == lpLastBit)
                begin
                    frameActive <= 1'b0;        // stop bit finished
                end
                else
                begin
                    bitIdx <= bitIdx + 1'b1;
                    if (bitIdx < lpDataEnd)
                    begin
                        txd      <= shiftReg[0];    // LSB first
                        shiftReg <= shiftReg >> 1;
                    end
                    else
                    begin
                        txd <= 1'b1;            // stop bit
                    end
                end
            end
            else
            begin
                clkCnt <= clkCnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/hexLinePrinter.sv ====
//----------------------------------------
// telemetry line printer top level
// sample + channel in over req/ack, one
// "Cnn=hhhh\n" line out on txd at 8N1
//----------------------------------------
`timescale 1ns/100ps

module hexLinePrinter #(
    parameter int pBitLen    = 16,                          // 4 x hex digits
    parameter int pClkPerBit = uartPkg::defaultClkPerBit
)(
    input  logic                            iSysClk,
    input  logic                            rstN,
    input  logic                            sampleReq,
    input  logic [pBitLen-1:0]              sampleData,
    input  logic [printerPkg::chanBits-1:0] channelId,
    output logic                            sampleAck,
    output logic                            txd,
    output logic                            txBusy
);

    // capture to both pipelines
    logic                              captureStrobe;
    logic [pBitLen-1:0]                capturedData;
    logic [printerPkg::chanBits-1:0]   capturedChan;
    // pipeline results
    logic [2*pBitLen+7:0]              asciiLine;
    logic                              asciiValid;
    logic [printerPkg::labelLen*8-1:0] labelBytes;
    logic                              labelValid;
    // byte handshake
    logic                              byteReq;
    logic [7:0]                        byteData;
    logic                              byteAck;
    logic                              frameActive;

    hexAsciiConvert #(.pBitLen(pBitLen)) u_hexAsciiConvert (
        .iSysClk(iSysClk), .rstN(rstN), .captureStrobe(captureStrobe),
        .capturedData(capturedData), .asciiLine(asciiLine), .asciiValid(asciiValid)
    );

    channelLabelGen u_channelLabelGen (
        .iSysClk(iSysClk), .rstN(rstN), .captureStrobe(captureStrobe),
        .capturedChan(capturedChan), .labelBytes(labelBytes), .labelValid(labelValid)
    );

    lineAssembler #(.pBitLen(pBitLen)) u_lineAssembler (
        .iSysClk(iSysClk), .rstN(rstN),
        .sampleReq(sampleReq), .sampleData(sampleData), .channelId(channelId),
        .sampleAck(sampleAck), .captureStrobe(captureStrobe),
        .capturedData(capturedData), .capturedChan(capturedChan),
        .asciiLine(asciiLine), .asciiValid(asciiValid),
        .labelBytes(labelBytes), .labelValid(labelValid),
        .byteReq(byteReq), .byteData(byteData), .byteAck(byteAck),
        .frameActive(frameActive), .txBusy(txBusy)
    );

    uartTx #(.pClkPerBit(pClkPerBit)) u_uartTx (
        .iSysClk(iSysClk), .rstN(rstN), .byteReq(byteReq), .byteData(byteData),
        .byteAck(byteAck), .txd(txd), .frameActive(frameActive)
    );

endmodule

// ==== verification/hexLinePrinterTb.sv ====
//----------------------------------------
// testbench for the hex line printer
// reads its tests from sampleInput.txt and runs
// the producer req/ack handshake
// txd is decoded back into bytes and every line
// is compared with the expected bytes
//----------------------------------------
`timescale 1ns/100ps

module hexLinePrinterTb;

    localparam int bitLen       = 16;
    localparam int clkPerBit    = 8;    // short bit period for simulation
    localparam int bytesPerLine = 9;

    logic                            iSysClk;
    logic                            rstN;
    logic                            sampleReq;
    logic [bitLen-1:0]               sampleData;
    logic [printerPkg::chanBits-1:0] channelId;
    logic                            sampleAck;
    logic                            txd;
    logic                            txBusy;

    // tests and nine expected bytes per test
    logic [printerPkg::chanBits-1:0] chanList   [$];
    logic [bitLen-1:0]               sampleList [$];
    logic [7:0]                      expList    [$];
    logic [7:0]                      rxQueue    [$];   // decoded from txd

    integer seed;
    int     numTests     = 0;
    int     linesChecked = 0;
    int     fallCount    = 0;   // txBusy falling edges
    int     cycleCount   = 0;
    int     cycleLimit   = 0;   // 0 until the tests are loaded
    logic   prevAck      = 1'b0;
    logic   prevReq      = 1'b0;
    logic   prevBusy     = 1'b0;

    hexLinePrinter #(.pBitLen(bitLen), .pClkPerBit(clkPerBit)) u_dut (
        .iSysClk(iSysClk), .rstN(rstN), .sampleReq(sampleReq),
        .sampleData(sampleData), .channelId(channelId), .sampleAck(sampleAck),
        .txd(txd), .txBusy(txBusy)
    );

    initial
    begin
        iSysClk = 1'b0;
        forever #4 iSysClk = ~iSysClk;  // 8 ns period
    end

    //----------------------------------------
    // reporting
    //----------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, actual, expected);
            abortRun("stopped at the first mismatch");
        end
    endtask

    //----------------------------------------
    // test file
    //----------------------------------------
    task automatic loadTests();
        int    fd;
        int    code;
        int    fields [11];
        string lineText;
        fd = $fopen("verification/sampleInput.txt", "r");
        if (fd == 0)
            abortRun("cannot open verification/sampleInput.txt");
        else
        begin
            while (!$feof(fd))
            begin
                lineText = "";
                code = $fgets(lineText, fd);
                // skip blank and '#' lines
                if (code > 0 && lineText.len() > 1 && lineText[0] != 8'h23)
                begin
                    code = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h",
                                   fields[0], fields[1], fields[2], fields[3],
                                   fields[4], fields[5], fields[6], fields[7],
                                   fields[8], fields[9], fields[10]);
                    if (code != 11)
                        abortRun({"malformed line in the test file: ", lineText});
                    else
                    begin
                        chanList.push_back(fields[0][printerPkg::chanBits-1:0]);
                        sampleList.push_back(fields[1][bitLen-1:0]);
                        for (int k = 2; k < 11; k++)
                            expList.push_back(fields[k][7:0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //----------------------------------------
    // UART decoder sampling mid-bit on negedge
    //----------------------------------------
    task automatic receiveFrame();
        logic [7:0] data;
        repeat (clkPerBit / 2) @(negedge iSysClk);     // middle of start bit
        checkEqual("txd start bit", txd, 1'b0);
        for (int b = 0; b < 8; b++)
        begin
            repeat (clkPerBit) @(negedge iSysClk);
            data[b] = txd;                              // LSB first
        end
        repeat (clkPerBit) @(negedge iSysClk);
        checkEqual("txd stop bit", txd, 1'b1);
        checkEqual("txBusy during frame", txBusy, 1'b1);
        rxQueue.push_back(data);
    endtask

    initial
    begin
        forever
        begin
            @(negedge iSysClk);
            if (rstN === 1'b1 && txd === 1'b0)
                receiveFrame();
        end
    end

    //----------------------------------------
    // handshake order and txBusy edges
    //----------------------------------------
    always @(negedge iSysClk)
    begin
        if (rstN === 1'b1)
        begin
            if (sampleAck && !prevAck)
            begin
                checkEqual("sampleReq at sampleAck rise", sampleReq, 1'b1);
                checkEqual("txBusy before sampleAck rise", prevBusy, 1'b0);
            end
            if (!sampleAck && prevAck)
                checkEqual("sampleReq before sampleAck fall", prevReq, 1'b0);
            if (!txBusy && prevBusy)
                fallCount = fallCount + 1;
        end
        prevAck  = sampleAck;
        prevReq  = sampleReq;
        prevBusy = txBusy;
    end

    // run limit from the number of lines
    always @(posedge iSysClk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
            abortRun($sformatf("timeout after %0d cycles with %0d of %0d lines checked",
                               cycleCount, linesChecked, numTests));
    end

    //----------------------------------------
    // producer and line checker
    //----------------------------------------
    task automatic driveRequests();
        int gap;
        for (int t = 0; t < numTests; t++)
        begin
            gap = $random(seed) & 7;        // 0 to 7 idle cycles
            if (t % 4 == 1)
                gap = 0;                    // next request right after the release
            repeat (gap) @(posedge iSysClk);
            @(posedge iSysClk);
            sampleData <= sampleList[t];
            channelId  <= chanList[t];
            sampleReq  <= 1'b1;
            // waits here while the previous line is still going out
            @(negedge iSysClk);
            while (sampleAck !== 1'b1)
                @(negedge iSysClk);
            @(posedge iSysClk);
            sampleReq  <= 1'b0;
            sampleData <= ~sampleList[t];   // data free to change now
            @(negedge iSysClk);
            while (sampleAck !== 1'b0)
                @(negedge iSysClk);
        end
    endtask

    task automatic checkLines();
        logic [7:0] got;
        for (int t = 0; t < numTests; t++)
        begin
            for (int j = 0; j < bytesPerLine; j++)
            begin
                while (rxQueue.size() == 0)
                    @(negedge iSysClk);
                got = rxQueue.pop_front();
                if (j == 0)
                    checkEqual("txBusy falls before next line", fallCount, t);
                checkEqual($sformatf("txd line %0d byte %0d", t, j), got,
                           expList[t*bytesPerLine+j]);
            end
            linesChecked = linesChecked + 1;
        end
    endtask

    initial
    begin
        seed = 32'hb29d;
        rstN       <= 1'b0;
        sampleReq  <= 1'b0;
        sampleData <= '0;
        channelId  <= '0;
        loadTests();
        numTests = chanList.size();
        if (numTests == 0)
            abortRun("no tests found in verification/sampleInput.txt");
        // nine frames of ten bits per line plus slack
        cycleLimit = numTests * (bytesPerLine * 10 * clkPerBit + 200);

        repeat (4) @(posedge iSysClk);
        rstN <= 1'b1;

        // idle outputs after reset
        repeat (4)
        begin
            @(negedge iSysClk);
            checkEqual("txd", txd, 1'b1);
            checkEqual("sampleAck", sampleAck, 1'b0);
            checkEqual("txBusy", txBusy, 1'b0);
        end

        fork
            driveRequests();
            checkLines();
        join

        // nothing extra on the wire after the last line
        repeat (20 * clkPerBit) @(negedge iSysClk);
        checkEqual("txBusy falls per line", fallCount, numTests);
        checkEqual("extra decoded bytes", rxQueue.size(), 0);
        checkEqual("txd", txd, 1'b1);
        checkEqual("txBusy", txBusy, 1'b0);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verification/sampleInput.txt ====
# columns: channel, sample, then the nine expected line bytes
# all values hex, one test per line
0 0000 43 30 30 3d 30 30 30 30 0a
f ffff 43 31 35 3d 66 66 66 66 0a
5 a5c3 43 30 35 3d 61 35 63 33 0a
a 1234 43 31 30 3d 31 32 33 34 0a
9 89ab 43 30 39 3d 38 39 61 62 0a
1 cdef 43 30 31 3d 63 64 65 66 0a
c 0f0f 43 31 32 3d 30 66 30 66 0a
7 7e01 43 30 37 3d 37 65 30 31 0a
b dead 43 31 31 3d 64 65 61 64 0a
e beef 43 31 34 3d 62 65 65 66 0a
3 9999 43 30 33 3d 39 39 39 39 0a
d 5a5a 43 31 33 3d 35 61 35 61 0a
2 0001 43 30 32 3d 30 30 30 31 0a
8 8000 43 30 38 3d 38 30 30 30 0a
6 6b2f 43 30 36 3d 36 62 32 66 0a
4 fa09 43 30 34 3d 66 61 30 39 0a

// ==== hexLinePrinter.f ====
hdl/printerPkg.sv
hdl/uartPkg.sv
hdl/hexAsciiConvert.sv
hdl/channelLabelGen.sv
hdl/lineAssembler.sv
hdl/uartTx.sv
hdl/hexLinePrinter.sv
verification/hexLinePrinterTb.sv

// ==== Makefile ====
# Verilator build and run of the hex line printer testbench

SIM      := verilator
TOP      := hexLinePrinterTb
FILELIST := hexLinePrinter.f
OBJDIR   := obj_dir
FLAGS    := --binary --timing -j 0 -Wno-fatal --Mdir $(OBJDIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run exits non-zero when the testbench stops with a fatal error
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
